/* hw/cpu_pkg.sv */
package cpu_pkg;

    // data path and register file sizes
    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    // operations the execute stage can perform
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    // 3R and 2RI5 forms, matched against inst[31:15]
    localparam logic [16:0] OP17_ADD_W  = 17'h00020;
    localparam logic [16:0] OP17_SUB_W  = 17'h00022;
    localparam logic [16:0] OP17_SLT    = 17'h00024;
    localparam logic [16:0] OP17_SLTU   = 17'h00025;
    localparam logic [16:0] OP17_AND    = 17'h00029;
    localparam logic [16:0] OP17_OR     = 17'h0002A;
    localparam logic [16:0] OP17_XOR    = 17'h0002B;
    localparam logic [16:0] OP17_SLLI_W = 17'h00081;
    localparam logic [16:0] OP17_SRLI_W = 17'h00089;
    localparam logic [16:0] OP17_SRAI_W = 17'h00091;

    // 2RI12 form, matched against inst[31:22]
    localparam logic [9:0] OP10_ADDI_W = 10'h00A;

    // 1RI20 form, matched against inst[31:25]
    localparam logic [6:0] OP7_LU12I_W = 7'h0A;

    // field positions inside the instruction word
    localparam int RD_LSB   = 0;
    localparam int RJ_LSB   = 5;
    localparam int RK_LSB   = 10;
    localparam int UI5_LSB  = 10;
    localparam int SI12_LSB = 10;
    localparam int SI12_W   = 12;
    localparam int SI20_LSB = 5;
    localparam int SI20_W   = 20;

endpackage

/* hw/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode import cpu_pkg::*; #(
    parameter logic [XLEN-1:0] PC_RESET = 32'h1C00_0000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    input  logic [XLEN-1:0]   inst,
    // register file write port from the result stage
    input  logic              rf_we,
    input  logic [REG_AW-1:0] rf_waddr,
    input  logic [XLEN-1:0]   rf_wdata,
    // instruction one ahead, for bypass
    input  logic              es_valid,
    input  logic              es_wen,
    input  logic [REG_AW-1:0] es_dest,
    input  logic [XLEN-1:0]   es_result,
    output logic              ds_valid,
    output logic [XLEN-1:0]   ds_pc,
    output alu_op_t           ds_op,
    output logic [XLEN-1:0]   ds_src1,
    output logic [XLEN-1:0]   ds_src2,
    output logic [REG_AW-1:0] ds_dest,
    output logic              ds_wen
);

    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   rf [NUM_REGS];

    logic [16:0]       op17;
    logic [9:0]        op10;
    logic [6:0]        op7;
    logic [REG_AW-1:0] inst_rd;
    logic [SI12_W-1:0] inst_si12;
    logic              dec_known;
    alu_op_t           dec_op;
    logic              dec_use_imm;
    logic [XLEN-1:0]   dec_imm;

    // decoded fields held for the operand read
    logic [REG_AW-1:0] ds_rj;
    logic [REG_AW-1:0] ds_rk;
    logic              ds_use_imm;
    logic [XLEN-1:0]   ds_imm;

    assign op17      = inst[31 -: 17];
    assign op10      = inst[31 -: 10];
    assign op7       = inst[31 -: 7];
    assign inst_rd   = inst[RD_LSB +: REG_AW];
    assign inst_si12 = inst[SI12_LSB +: SI12_W];

    // one word per accepted strobe, never refused
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= PC_RESET;
        end else if (inst_valid) begin
            pc <= pc + 32'd4;
        end
    end

    always_comb begin
        dec_known   = 1'b1;
        dec_op      = ALU_ADD;
        dec_use_imm = 1'b0;
        dec_imm     = '0;
        if (op7 == OP7_LU12I_W) begin
            dec_op      = ALU_LUI;
            dec_use_imm = 1'b1;
            dec_imm     = {inst[SI20_LSB +: SI20_W], {(XLEN-SI20_W){1'b0}}};
        end else if (op10 == OP10_ADDI_W) begin
            dec_use_imm = 1'b1;
            dec_imm     = {{(XLEN-SI12_W){inst_si12[SI12_W-1]}}, inst_si12};
        end else begin
            // shift amount for the immediate shifts
            dec_imm = {{(XLEN-REG_AW){1'b0}}, inst[UI5_LSB +: REG_AW]};
            case (op17)
                OP17_ADD_W:  dec_op = ALU_ADD;
                OP17_SUB_W:  dec_op = ALU_SUB;
                OP17_SLT:    dec_op = ALU_SLT;
                OP17_SLTU:   dec_op = ALU_SLTU;
                OP17_AND:    dec_op = ALU_AND;
                OP17_OR:     dec_op = ALU_OR;
                OP17_XOR:    dec_op = ALU_XOR;
                OP17_SLLI_W: begin
                    dec_op      = ALU_SLL;
                    dec_use_imm = 1'b1;
                end
                OP17_SRLI_W: begin
                    dec_op      = ALU_SRL;
                    dec_use_imm = 1'b1;
                end
                OP17_SRAI_W: begin
                    dec_op      = ALU_SRA;
                    dec_use_imm = 1'b1;
                end
                default:     dec_known = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ds_valid <= 1'b0;
        end else begin
            ds_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            ds_pc      <= pc;
            ds_op      <= dec_op;
            ds_dest    <= inst_rd;
            ds_wen     <= dec_known && (inst_rd != '0);
            ds_rj      <= inst[RJ_LSB +: REG_AW];
            ds_rk      <= inst[RK_LSB +: REG_AW];
            ds_use_imm <= dec_use_imm;
            ds_imm     <= dec_imm;
        end
    end

    // written at the edge that retires the result register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_we && rf_waddr != '0) begin
            rf[rf_waddr] <= rf_wdata;
        end
    end

    // execute is younger than the result register, so it wins
    function automatic logic [XLEN-1:0] read_reg(input logic [REG_AW-1:0] addr);
        logic [XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (es_valid && es_wen && es_dest == addr) begin
            value = es_result;
        end else if (rf_we && rf_waddr == addr) begin
            value = rf_wdata;
        end else begin
            value = rf[addr];
        end
        return value;
    endfunction

    always_comb begin
        ds_src1 = read_reg(ds_rj);
        ds_src2 = ds_use_imm ? ds_imm : read_reg(ds_rk);
    end

endmodule

/* hw/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              ds_valid,
    input  logic [XLEN-1:0]   ds_pc,
    input  alu_op_t           ds_op,
    input  logic [XLEN-1:0]   ds_src1,
    input  logic [XLEN-1:0]   ds_src2,
    input  logic [REG_AW-1:0] ds_dest,
    input  logic              ds_wen,
    output logic              es_valid,
    output logic [XLEN-1:0]   es_pc,
    output logic [REG_AW-1:0] es_dest,
    output logic              es_wen,
    output logic [XLEN-1:0]   es_result
);

    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_out;

    // shifts only look at the low five bits
    assign shamt = ds_src2[4:0];

    always_comb begin
        case (ds_op)
            ALU_ADD:  alu_out = ds_src1 + ds_src2;
            ALU_SUB:  alu_out = ds_src1 - ds_src2;
            ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(ds_src1) < $signed(ds_src2)};
            ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, ds_src1 < ds_src2};
            ALU_AND:  alu_out = ds_src1 & ds_src2;
            ALU_OR:   alu_out = ds_src1 | ds_src2;
            ALU_XOR:  alu_out = ds_src1 ^ ds_src2;
            ALU_SLL:  alu_out = ds_src1 << shamt;
            ALU_SRL:  alu_out = ds_src1 >> shamt;
            ALU_SRA:  alu_out = $unsigned($signed(ds_src1) >>> shamt);
            // immediate already shifted in decode
            ALU_LUI:  alu_out = ds_src2;
            default:  alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            es_valid <= 1'b0;
        end else begin
            es_valid <= ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_valid) begin
            es_pc     <= ds_pc;
            es_dest   <= ds_dest;
            es_wen    <= ds_wen;
            es_result <= alu_out;
        end
    end

endmodule

/* hw/wb_result.sv */
`timescale 1ns/1ps

module wb_result import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              es_valid,
    input  logic [XLEN-1:0]   es_pc,
    input  logic [REG_AW-1:0] es_dest,
    input  logic              es_wen,
    input  logic [XLEN-1:0]   es_result,
    output logic              rf_we,
    output logic [REG_AW-1:0] rf_waddr,
    output logic [XLEN-1:0]   rf_wdata,
    output logic [XLEN-1:0]   debug_wb_pc,
    output logic [3:0]        debug_wb_rf_we,
    output logic [REG_AW-1:0] debug_wb_rf_wnum,
    output logic [XLEN-1:0]   debug_wb_rf_wdata
);

    logic              ws_we;
    logic [REG_AW-1:0] ws_dest;
    logic [XLEN-1:0]   ws_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            ws_we       <= 1'b0;
            debug_wb_pc <= '0;
        end else begin
            ws_we <= es_valid && es_wen;
            // holds the last retired pc between instructions
            if (es_valid) begin
                debug_wb_pc <= es_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (es_valid) begin
            ws_dest   <= es_dest;
            ws_result <= es_result;
        end
    end

    // write port back to decode, also the oldest bypass source
    assign rf_we    = ws_we;
    assign rf_waddr = ws_dest;
    assign rf_wdata = ws_result;

    // trace strobe is all bytes or nothing
    assign debug_wb_rf_we    = {4{ws_we}};
    assign debug_wb_rf_wnum  = ws_dest;
    assign debug_wb_rf_wdata = ws_result;

endmodule

/* hw/mini_cpu.sv */
`timescale 1ns/1ps

module mini_cpu import cpu_pkg::*; #(
    parameter logic [XLEN-1:0] PC_RESET = 32'h1C00_0000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    input  logic [XLEN-1:0]   inst,
    // trace debug outputs
    output logic [XLEN-1:0]   debug_wb_pc,
    output logic [3:0]        debug_wb_rf_we,
    output logic [REG_AW-1:0] debug_wb_rf_wnum,
    output logic [XLEN-1:0]   debug_wb_rf_wdata
);

    // decode to execute
    logic              ds_valid;
    logic [XLEN-1:0]   ds_pc;
    alu_op_t           ds_op;
    logic [XLEN-1:0]   ds_src1;
    logic [XLEN-1:0]   ds_src2;
    logic [REG_AW-1:0] ds_dest;
    logic              ds_wen;

    // execute to result
    logic              es_valid;
    logic [XLEN-1:0]   es_pc;
    logic [REG_AW-1:0] es_dest;
    logic              es_wen;
    logic [XLEN-1:0]   es_result;

    // result back to decode
    logic              rf_we;
    logic [REG_AW-1:0] rf_waddr;
    logic [XLEN-1:0]   rf_wdata;

    inst_decode #(
        .PC_RESET   (PC_RESET)
    ) inst_decode_inst (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .es_valid   (es_valid),
        .es_wen     (es_wen),
        .es_dest    (es_dest),
        .es_result  (es_result),
        .ds_valid   (ds_valid),
        .ds_pc      (ds_pc),
        .ds_op      (ds_op),
        .ds_src1    (ds_src1),
        .ds_src2    (ds_src2),
        .ds_dest    (ds_dest),
        .ds_wen     (ds_wen)
    );

    alu_execute alu_execute_inst (
        .clk        (clk),
        .rst        (rst),
        .ds_valid   (ds_valid),
        .ds_pc      (ds_pc),
        .ds_op      (ds_op),
        .ds_src1    (ds_src1),
        .ds_src2    (ds_src2),
        .ds_dest    (ds_dest),
        .ds_wen     (ds_wen),
        .es_valid   (es_valid),
        .es_pc      (es_pc),
        .es_dest    (es_dest),
        .es_wen     (es_wen),
        .es_result  (es_result)
    );

    wb_result wb_result_inst (
        .clk               (clk),
        .rst               (rst),
        .es_valid          (es_valid),
        .es_pc             (es_pc),
        .es_dest           (es_dest),
        .es_wen            (es_wen),
        .es_result         (es_result),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

/* test/mini_cpu_props.sv */
`timescale 1ns/1ps

module mini_cpu_props import cpu_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic              inst_valid,
    input logic [3:0]        debug_wb_rf_we,
    input logic [REG_AW-1:0] debug_wb_rf_wnum
);

    // trace strobe is all bytes or none
    strobe_whole: assert property (@(posedge clk) disable iff (rst)
        debug_wb_rf_we == 4'h0 || debug_wb_rf_we == 4'hF)
        else $error("trace write strobe is partial");

    // r0 never shows up as a destination
    no_r0_write: assert property (@(posedge clk) disable iff (rst)
        debug_wb_rf_we != 4'h0 |-> debug_wb_rf_wnum != '0)
        else $error("trace write to r0");

    // quiet during reset and for one cycle after
    quiet_in_reset: assert property (@(posedge clk)
        rst |=> (debug_wb_rf_we == 4'h0) [*2])
        else $error("trace write during reset");

    // every retired write was accepted three edges earlier
    write_latency: assert property (@(posedge clk) disable iff (rst)
        debug_wb_rf_we != 4'h0 |-> $past(inst_valid, 3))
        else $error("trace write without an accepted word three cycles before");

endmodule

bind mini_cpu mini_cpu_props mini_cpu_props_inst (
    .clk              (clk),
    .rst              (rst),
    .inst_valid       (inst_valid),
    .debug_wb_rf_we   (debug_wb_rf_we),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

/* test/tb_mini_cpu.sv */
`timescale 1ns/1ps

module tb_mini_cpu;

    localparam logic [31:0] PC_START    = 32'h1C00_0000;
    localparam logic [31:0] SEED        = 32'd59;
    localparam int          DRAIN_LIMIT = 20;
    localparam int          LATENCY     = 3;

    // add.w sub.w slt sltu and or xor from index 0 up
    localparam logic [6:0][16:0] RR_OPS = {17'h0002B, 17'h0002A, 17'h00029,
        17'h00025, 17'h00024, 17'h00022, 17'h00020};
    // slli.w srli.w srai.w
    localparam logic [2:0][16:0] SH_OPS = {17'h00091, 17'h00089, 17'h00081};
    localparam logic [9:0] ADDI_W = 10'h00A;
    localparam logic [6:0] LU12I_W = 7'h0A;

    logic        clk;
    logic        rst;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // reference model state and expected writes
    logic [31:0] m_regs [32];
    logic [31:0] m_pc;
    logic [31:0] q_pc [$];
    logic [4:0]  q_rd [$];
    logic [31:0] q_val [$];
    int          q_acc [$];

    logic [31:0] rng_state;
    int          cycle = 0;
    int          errors;
    int          checks;
    int          tests;

    mini_cpu mini_cpu_inst (
        .clk               (clk),
        .rst               (rst),
        .inst_valid        (inst_valid),
        .inst              (inst),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // registers r0 to r7 only so hazards are frequent
    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = next_rand();
        return {2'b00, r[2:0]};
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk,
                                          input logic [4:0] rj, input logic [4:0] rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri12(input logic [11:0] si12, input logic [4:0] rj,
                                             input logic [4:0] rd);
        return {ADDI_W, si12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_1ri20(input logic [19:0] si20, input logic [4:0] rd);
        return {LU12I_W, si20, rd};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // compare one retired write against the oldest expected entry
    task automatic check_trace();
        int retire;
        if (debug_wb_rf_we != 4'h0) begin
            if (q_pc.size() == 0) begin
                errors++;
                $display("unexpected write to r%0d at %0d ns with nothing pending",
                         debug_wb_rf_wnum, $time);
            end else begin
                // the write retires at the coming rising edge
                retire = cycle + 1;
                check_value("strobe", {28'b0, debug_wb_rf_we}, 32'h0000_000F);
                check_value("pc", debug_wb_pc, q_pc.pop_front());
                check_value("rd", {27'b0, debug_wb_rf_wnum}, {27'b0, q_rd.pop_front()});
                check_value("data", debug_wb_rf_wdata, q_val.pop_front());
                check_value("latency", retire - q_acc.pop_front(), LATENCY);
            end
        end
    endtask

    task automatic tick();
        @(negedge clk);
        check_trace();
    endtask

    task automatic idle();
        tick();
        inst_valid = 1'b0;
        inst       = next_rand();
    endtask

    task automatic issue(input logic [31:0] word);
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic        known;
        tick();
        inst_valid = 1'b1;
        inst       = word;
        rd    = word[4:0];
        sh    = word[14:10];
        a     = m_regs[word[9:5]];
        b     = m_regs[word[14:10]];
        known = 1'b1;
        val   = '0;
        if (word[31:25] == LU12I_W) begin
            val = {word[24:5], 12'h000};
        end else if (word[31:22] == ADDI_W) begin
            val = a + {{20{word[21]}}, word[21:10]};
        end else begin
            case (word[31:15])
                17'h00020: val = a + b;
                17'h00022: val = a - b;
                17'h00024: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                17'h00025: val = (a < b) ? 32'd1 : 32'd0;
                17'h00029: val = a & b;
                17'h0002A: val = a | b;
                17'h0002B: val = a ^ b;
                17'h00081: val = a << sh;
                17'h00089: val = a >> sh;
                17'h00091: val = $signed(a) >>> sh;
                default:   known = 1'b0;
            endcase
        end
        if (known && rd != 5'd0) begin
            m_regs[rd] = val;
            q_pc.push_back(m_pc);
            q_rd.push_back(rd);
            q_val.push_back(val);
            q_acc.push_back(cycle + 1);
        end
        // every accepted word moves the pc whether legal or not
        m_pc = m_pc + 32'd4;
    endtask

    // about a third of the words come after an idle cycle
    task automatic issue_gap(input logic [31:0] word);
        if (next_rand() % 10 < 3) begin
            idle();
        end
        issue(word);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        int waited;
        waited = 0;
        while (q_pc.size() != 0 && waited < DRAIN_LIMIT) begin
            idle();
            waited++;
        end
        if (q_pc.size() != 0) begin
            errors++;
            $display("timeout in test %s: %0d writes never reached the trace port",
                     name, q_pc.size());
            q_pc.delete();
            q_rd.delete();
            q_val.delete();
            q_acc.delete();
        end
        // catch stray writes behind the last expected one
        repeat (LATENCY) idle();
        tests++;
        $display("test %s done, %0d errors", name, errors - errs_before);
    endtask

    initial begin
        int          e0;
        logic [31:0] r;
        logic [4:0]  d;
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        rng_state  = SEED;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        m_pc       = PC_START;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst = 1'b0;

        // lu12i.w and addi.w seed the registers first
        e0 = errors;
        for (int i = 0; i < 24; i++) begin
            r = next_rand();
            case (i % 3)
                0: issue_gap(enc_1ri20(r[31:12], rand_reg()));
                1: issue_gap(enc_2ri12(r[11:0] | 12'h800, rand_reg(), rand_reg()));
                default: issue_gap(enc_2ri12(r[11:0], rand_reg(), rand_reg()));
            endcase
        end
        finish_test("imm_ops", e0);

        e0 = errors;
        for (int i = 0; i < 40; i++) begin
            issue_gap(enc_3r(RR_OPS[next_rand() % 7], rand_reg(), rand_reg(), rand_reg()));
        end
        finish_test("reg_reg_ops", e0);

        e0 = errors;
        for (int i = 0; i < 30; i++) begin
            r = next_rand();
            issue_gap(enc_3r(SH_OPS[r % 3], r[12:8], rand_reg(), rand_reg()));
        end
        finish_test("shifts", e0);

        // producer then consumer of the same register with 0 to 2 idle cycles between
        e0 = errors;
        for (int gap = 0; gap < 3; gap++) begin
            for (int i = 0; i < 6; i++) begin
                d = 5'd1 + next_rand() % 7;
                issue(enc_3r(RR_OPS[next_rand() % 7], rand_reg(), rand_reg(), d));
                repeat (gap) idle();
                issue(enc_3r(RR_OPS[next_rand() % 7], rand_reg(), d, rand_reg()));
            end
        end
        finish_test("bypass", e0);

        e0 = errors;
        for (int i = 0; i < 24; i++) begin
            r = next_rand();
            case (r % 4)
                0: issue_gap(enc_3r(RR_OPS[r[10:8] % 7], rand_reg(), rand_reg(), 5'd0));
                1: issue_gap({7'h7F, r[24:0]});
                2: issue_gap(enc_3r(RR_OPS[0], 5'd0, 5'd0, rand_reg()));
                default: issue_gap(enc_2ri12(r[11:0], 5'd0, rand_reg()));
            endcase
        end
        finish_test("r0_and_illegal", e0);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* mini_cpu.f */
hw/cpu_pkg.sv
hw/inst_decode.sv
hw/alu_execute.sv
hw/wb_result.sv
hw/mini_cpu.sv
test/mini_cpu_props.sv
test/tb_mini_cpu.sv
